// File: Bender.yml
package:
  name: csr_unit

sources:
  - include_dirs:
      - .
    files:
      - csr_isa_pkg.sv
      - csr_reg_pkg.sv
      - csr_decode.sv
      - csr_execute.sv
      - csr_regfile.sv
      - csr_unit.sv
  - target: test
    include_dirs:
      - .
    files:
      - csr_unit_sva.sv
      - csr_unit_tb.sv

// File: all.f
+incdir+.
csr_isa_pkg.sv
csr_reg_pkg.sv
csr_decode.sv
csr_execute.sv
csr_regfile.sv
csr_unit.sv
csr_unit_sva.sv
csr_unit_tb.sv

// File: csr_consts.svh
/* Machine-mode CSR constants for RV32 only. Addresses outside the list below read as zero
   and ignore writes. */

`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// Datapath and field widths
`define CSR_XLEN        32
`define CSR_ADDR_W      12
`define CSR_REG_W       5
`define CSR_FUNCT3_W    3
`define CSR_OPCODE_W    7

// SYSTEM opcode funct3 codes for the Zicsr group
`define CSR_F3_CSRRW    3'b001
`define CSR_F3_CSRRS    3'b010
`define CSR_F3_CSRRC    3'b011
`define CSR_F3_CSRRWI   3'b101
`define CSR_F3_CSRRSI   3'b110
`define CSR_F3_CSRRCI   3'b111

// Machine CSR addresses
`define CSR_ADDR_MSTATUS    12'h300
`define CSR_ADDR_MISA       12'h301
`define CSR_ADDR_MIE        12'h304
`define CSR_ADDR_MTVEC      12'h305
`define CSR_ADDR_MSCRATCH   12'h340
`define CSR_ADDR_MEPC       12'h341
`define CSR_ADDR_MCAUSE     12'h342
`define CSR_ADDR_MTVAL      12'h343
`define CSR_ADDR_MIP        12'h344
`define CSR_ADDR_MHARTID    12'hF14

// Bits kept on mstatus and mepc writes
`define CSR_MSTATUS_WMASK   32'h807F_F9BB
`define CSR_MEPC_WMASK      32'hFFFF_FFFC

// MXL=1 with the I base only
`define CSR_MISA_VALUE      32'h4000_0100

// Interrupt bit positions in mip and mie
`define CSR_MEIP_BIT    11
`define CSR_MTIP_BIT    7
`define CSR_MSIP_BIT    3

// Flops per interrupt pin synchronizer
`define CSR_SYNC_DEPTH  2

`endif

// File: csr_decode.sv
/* One instruction in flight. ready drops for two cycles after each acceptance and
   rs1_val must be valid in the same cycle as rs1_addr. */

`timescale 1ns/10ps

`include "csr_consts.svh"

module csr_decode (
    input  logic                     aclk,
    input  logic                     aresetn,
    input  logic                     valid,
    output logic                     ready,
    input  csr_isa_pkg::csr_instr_t  instbus,
    output logic [`CSR_REG_W-1:0]    rs1_addr,
    input  logic [`CSR_XLEN-1:0]     rs1_val,
    output logic [`CSR_ADDR_W-1:0]   rd_addr,
    input  logic [`CSR_XLEN-1:0]     rd_data,
    output csr_isa_pkg::csr_op_t     op,
    output logic                     issue
);

    typedef enum logic [1:0] {
        st_idle,
        st_compute,
        st_store
    } state_e;

    state_e state_q;
    logic   accept;

    // Register file and CSR lookups run straight off the bus
    assign rs1_addr = instbus.src.rs1_idx;
    assign rd_addr  = instbus.csr_addr;

    assign ready  = (state_q == st_idle);
    assign accept = valid && ready;
    assign issue  = (state_q == st_compute);

    ////////////////////////////////////////////////////////////////////////////
    // Acceptance FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state_q <= st_idle;
        end else begin
            case (state_q)
                st_idle: begin
                    if (accept) begin
                        state_q <= st_compute;
                    end
                end
                st_compute: state_q <= st_store;
                // Store cycle lets the CSR write land before the next read
                default: state_q <= st_idle;
            endcase
        end
    end

    // Field capture with the pre-instruction CSR value
    always_ff @(posedge aclk) begin
        if (accept) begin
            op.funct3   <= instbus.funct3;
            op.src      <= instbus.src;
            op.rd       <= instbus.rd;
            op.csr_addr <= instbus.csr_addr;
            op.rs1_val  <= rs1_val;
            op.old_val  <= rd_data;
        end
    end

endmodule

// File: csr_execute.sv
/* Computes the new CSR value one cycle after issue. Undefined funct3 codes
   produce neither a destination write nor a CSR write. */

`timescale 1ns/10ps

`include "csr_consts.svh"

module csr_execute (
    input  logic                  aclk,
    input  logic                  aresetn,
    input  csr_isa_pkg::csr_op_t  op,
    input  logic                  issue,
    output csr_reg_pkg::rd_wr_t   rd_wr,
    output csr_reg_pkg::csr_wr_t  csr_wr
);

    logic                 op_valid;
    logic                 wr_req;
    logic [`CSR_XLEN-1:0] zimm_ext;
    logic [`CSR_XLEN-1:0] new_val;

    logic                 rd_en_q;
    logic                 csr_en_q;
    logic [`CSR_REG_W-1:0] rd_addr_q;
    logic [`CSR_XLEN-1:0] rd_data_q;
    logic [`CSR_ADDR_W-1:0] csr_addr_q;
    logic [`CSR_XLEN-1:0] csr_data_q;

    // Immediate is zero extended to XLEN
    assign zimm_ext = {{(`CSR_XLEN-`CSR_REG_W){1'b0}}, op.src.zimm};

    ////////////////////////////////////////////////////////////////////////////
    // Operation select
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        op_valid = 1'b1;
        wr_req   = 1'b1;
        new_val  = op.old_val;
        case (op.funct3)
            csr_isa_pkg::csrrw: new_val = op.rs1_val;
            csr_isa_pkg::csrrs: begin
                // x0 source means read only
                wr_req  = (op.src.rs1_idx != '0);
                new_val = op.old_val | op.rs1_val;
            end
            csr_isa_pkg::csrrc: begin
                wr_req  = (op.src.rs1_idx != '0);
                new_val = op.old_val & ~op.rs1_val;
            end
            csr_isa_pkg::csrrwi: new_val = zimm_ext;
            csr_isa_pkg::csrrsi: begin
                wr_req  = (op.src.zimm != '0);
                new_val = op.old_val | zimm_ext;
            end
            csr_isa_pkg::csrrci: begin
                wr_req  = (op.src.zimm != '0);
                new_val = op.old_val & ~zimm_ext;
            end
            default: begin
                op_valid = 1'b0;
                wr_req   = 1'b0;
            end
        endcase
    end

    // Write enables are single-cycle pulses
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            rd_en_q  <= 1'b0;
            csr_en_q <= 1'b0;
        end else begin
            rd_en_q  <= issue && op_valid;
            csr_en_q <= issue && wr_req;
        end
    end

    always_ff @(posedge aclk) begin
        if (issue) begin
            rd_addr_q  <= op.rd;
            rd_data_q  <= op.old_val;
            csr_addr_q <= op.csr_addr;
            csr_data_q <= new_val;
        end
    end

    assign rd_wr  = '{en: rd_en_q, addr: rd_addr_q, data: rd_data_q};
    assign csr_wr = '{en: csr_en_q, addr: csr_addr_q, data: csr_data_q};

endmodule

// File: csr_isa_pkg.sv
/* Instruction-side types. The funct3 field stays a plain vector so that
   undefined codes can flow through decode unchanged. */

`include "csr_consts.svh"

package csr_isa_pkg;

    // Zicsr operation codes
    typedef enum logic [`CSR_FUNCT3_W-1:0] {
        csrrw  = `CSR_F3_CSRRW,
        csrrs  = `CSR_F3_CSRRS,
        csrrc  = `CSR_F3_CSRRC,
        csrrwi = `CSR_F3_CSRRWI,
        csrrsi = `CSR_F3_CSRRSI,
        csrrci = `CSR_F3_CSRRCI
    } csr_funct3_e;

    // Bits 19:15 hold rs1 for register forms
    // and the immediate for the I forms
    typedef union packed {
        logic [`CSR_REG_W-1:0] rs1_idx;
        logic [`CSR_REG_W-1:0] zimm;
    } csr_src_u;

    // I-type layout of a SYSTEM instruction
    typedef struct packed {
        logic [`CSR_ADDR_W-1:0]   csr_addr;
        csr_src_u                 src;
        logic [`CSR_FUNCT3_W-1:0] funct3;
        logic [`CSR_REG_W-1:0]    rd;
        logic [`CSR_OPCODE_W-1:0] opcode;
    } csr_instr_t;

    // Captured operation handed from decode to execute
    typedef struct packed {
        logic [`CSR_FUNCT3_W-1:0] funct3;
        csr_src_u                 src;
        logic [`CSR_REG_W-1:0]    rd;
        logic [`CSR_ADDR_W-1:0]   csr_addr;
        logic [`CSR_XLEN-1:0]     rs1_val;
        logic [`CSR_XLEN-1:0]     old_val;
    } csr_op_t;

endpackage

// File: csr_reg_pkg.sv
/* Register-side traffic types. Trap strobes are sampled every clock edge and
   each one is independent of the others. */

`include "csr_consts.svh"

package csr_reg_pkg;

    // Write request into the CSR storage
    typedef struct packed {
        logic                   en;
        logic [`CSR_ADDR_W-1:0] addr;
        logic [`CSR_XLEN-1:0]   data;
    } csr_wr_t;

    // Destination register write back to the core
    typedef struct packed {
        logic                  en;
        logic [`CSR_REG_W-1:0] addr;
        logic [`CSR_XLEN-1:0]  data;
    } rd_wr_t;

    // Trap logic overrides
    typedef struct packed {
        logic                 mepc_wr;
        logic [`CSR_XLEN-1:0] mepc;
        logic                 mstatus_wr;
        logic [`CSR_XLEN-1:0] mstatus;
        logic                 mcause_wr;
        logic [`CSR_XLEN-1:0] mcause;
        logic                 mtval_wr;
        logic [`CSR_XLEN-1:0] mtval;
    } trap_wr_t;

    // Shared bus towards the rest of the core
    typedef struct packed {
        logic [`CSR_XLEN-1:0] mtvec;
        logic [`CSR_XLEN-1:0] mepc;
        logic [`CSR_XLEN-1:0] mstatus;
        logic                 meip;
        logic                 mtip;
        logic                 msip;
    } csr_sb_t;

endpackage

// File: csr_regfile.sv
/* Trap writes win over instruction writes in the same cycle. mip ignores
   instruction writes while any synchronized interrupt pin is high. */

`timescale 1ns/10ps

`include "csr_consts.svh"

module csr_regfile #(
    parameter logic [`CSR_XLEN-1:0] hart_id = '0
) (
    input  logic                    aclk,
    input  logic                    aresetn,
    input  csr_reg_pkg::csr_wr_t    csr_wr,
    input  csr_reg_pkg::trap_wr_t   trap_wr,
    input  logic                    ext_irq,
    input  logic                    timer_irq,
    input  logic                    sw_irq,
    input  logic [`CSR_ADDR_W-1:0]  rd_addr,
    output logic [`CSR_XLEN-1:0]    rd_data,
    output csr_reg_pkg::csr_sb_t    csr_sb
);

    logic [`CSR_XLEN-1:0] mstatus_q;
    logic [`CSR_XLEN-1:0] mie_q;
    logic [`CSR_XLEN-1:0] mtvec_q;
    logic [`CSR_XLEN-1:0] mscratch_q;
    logic [`CSR_XLEN-1:0] mepc_q;
    logic [`CSR_XLEN-1:0] mcause_q;
    logic [`CSR_XLEN-1:0] mtval_q;
    logic [`CSR_XLEN-1:0] mip_q;

    // Pin order is ext, timer, sw from the top
    logic [2:0]                           irq_pin;
    logic [2:0][`CSR_SYNC_DEPTH-1:0]      irq_sync_q;
    logic [2:0]                           irq_sync;
    logic [2:0]                           irq_set;

    ////////////////////////////////////////////////////////////////////////////
    // Interrupt synchronizers
    ////////////////////////////////////////////////////////////////////////////

    assign irq_pin = {ext_irq, timer_irq, sw_irq};

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            irq_sync_q <= '0;
        end else begin
            for (int i = 0; i < 3; i++) begin
                irq_sync_q[i] <= {irq_sync_q[i][`CSR_SYNC_DEPTH-2:0], irq_pin[i]};
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            irq_sync[i] = irq_sync_q[i][`CSR_SYNC_DEPTH-1];
        end
    end

    // Only enabled pins raise their pending bit
    assign irq_set = irq_sync & {mie_q[`CSR_MEIP_BIT], mie_q[`CSR_MTIP_BIT],
                                 mie_q[`CSR_MSIP_BIT]};

    ////////////////////////////////////////////////////////////////////////////
    // CSR storage
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            mstatus_q  <= '0;
            mie_q      <= '0;
            mtvec_q    <= '0;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mtval_q    <= '0;
        end else begin
            // Instruction writes first so trap strobes override them below
            if (csr_wr.en) begin
                case (csr_wr.addr)
                    `CSR_ADDR_MSTATUS:  mstatus_q  <= csr_wr.data & `CSR_MSTATUS_WMASK;
                    `CSR_ADDR_MIE:      mie_q      <= csr_wr.data;
                    `CSR_ADDR_MTVEC:    mtvec_q    <= csr_wr.data;
                    `CSR_ADDR_MSCRATCH: mscratch_q <= csr_wr.data;
                    `CSR_ADDR_MEPC:     mepc_q     <= csr_wr.data & `CSR_MEPC_WMASK;
                    `CSR_ADDR_MCAUSE:   mcause_q   <= csr_wr.data;
                    `CSR_ADDR_MTVAL:    mtval_q    <= csr_wr.data;
                    default: ;
                endcase
            end
            if (trap_wr.mstatus_wr) mstatus_q <= trap_wr.mstatus & `CSR_MSTATUS_WMASK;
            if (trap_wr.mepc_wr)    mepc_q    <= trap_wr.mepc & `CSR_MEPC_WMASK;
            if (trap_wr.mcause_wr)  mcause_q  <= trap_wr.mcause;
            if (trap_wr.mtval_wr)   mtval_q   <= trap_wr.mtval;
        end
    end

    // Sticky pending bits, software clears them once the pins drop
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            mip_q <= '0;
        end else if (|irq_sync) begin
            if (irq_set[2]) mip_q[`CSR_MEIP_BIT] <= 1'b1;
            if (irq_set[1]) mip_q[`CSR_MTIP_BIT] <= 1'b1;
            if (irq_set[0]) mip_q[`CSR_MSIP_BIT] <= 1'b1;
        end else if (csr_wr.en && (csr_wr.addr == `CSR_ADDR_MIP)) begin
            mip_q <= csr_wr.data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read port and shared bus
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (rd_addr)
            `CSR_ADDR_MSTATUS:  rd_data = mstatus_q;
            `CSR_ADDR_MISA:     rd_data = `CSR_MISA_VALUE;
            `CSR_ADDR_MIE:      rd_data = mie_q;
            `CSR_ADDR_MTVEC:    rd_data = mtvec_q;
            `CSR_ADDR_MSCRATCH: rd_data = mscratch_q;
            `CSR_ADDR_MEPC:     rd_data = mepc_q;
            `CSR_ADDR_MCAUSE:   rd_data = mcause_q;
            `CSR_ADDR_MTVAL:    rd_data = mtval_q;
            `CSR_ADDR_MIP:      rd_data = mip_q;
            `CSR_ADDR_MHARTID:  rd_data = hart_id;
            default:            rd_data = '0;
        endcase
    end

    assign csr_sb = '{mtvec:   mtvec_q,
                      mepc:    mepc_q,
                      mstatus: mstatus_q,
                      meip:    mip_q[`CSR_MEIP_BIT],
                      mtip:    mip_q[`CSR_MTIP_BIT],
                      msip:    mip_q[`CSR_MSIP_BIT]};

endmodule

// File: csr_unit.sv
/* Machine-mode CSR unit, one instruction every three cycles at best.
   Interrupt pins may be asynchronous to aclk. */

`timescale 1ns/10ps

`include "csr_consts.svh"

module csr_unit #(
    parameter logic [`CSR_XLEN-1:0] hart_id = '0
) (
    input  logic                     aclk,
    input  logic                     aresetn,
    // Instruction handshake
    input  logic                     valid,
    output logic                     ready,
    input  csr_isa_pkg::csr_instr_t  instbus,
    // Core register file access
    output logic [`CSR_REG_W-1:0]    rs1_addr,
    input  logic [`CSR_XLEN-1:0]     rs1_val,
    output csr_reg_pkg::rd_wr_t      rd_wr,
    // Trap and interrupt inputs
    input  csr_reg_pkg::trap_wr_t    trap_wr,
    input  logic                     ext_irq,
    input  logic                     timer_irq,
    input  logic                     sw_irq,
    output csr_reg_pkg::csr_sb_t     csr_sb
);

    csr_isa_pkg::csr_op_t   op;
    logic                   issue;
    csr_reg_pkg::csr_wr_t   csr_wr;
    logic [`CSR_ADDR_W-1:0] rd_addr;
    logic [`CSR_XLEN-1:0]   rd_data;

    // Accept and capture
    csr_decode u_decode (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .valid    (valid),
        .ready    (ready),
        .instbus  (instbus),
        .rs1_addr (rs1_addr),
        .rs1_val  (rs1_val),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .op       (op),
        .issue    (issue)
    );

    // New value and write pulses
    csr_execute u_execute (
        .aclk    (aclk),
        .aresetn (aresetn),
        .op      (op),
        .issue   (issue),
        .rd_wr   (rd_wr),
        .csr_wr  (csr_wr)
    );

    csr_regfile #(
        .hart_id (hart_id)
    ) u_regfile (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .csr_wr    (csr_wr),
        .trap_wr   (trap_wr),
        .ext_irq   (ext_irq),
        .timer_irq (timer_irq),
        .sw_irq    (sw_irq),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .csr_sb    (csr_sb)
    );

endmodule

// File: csr_unit_sva.sv
/* Protocol assertions bound into csr_unit. Checks stay quiet while aresetn is low,
   except the first-cycle check right after reset release. */

`timescale 1ns/10ps

module csr_unit_sva (
    input logic                 aclk,
    input logic                 aresetn,
    input logic                 valid,
    input logic                 ready,
    input csr_reg_pkg::rd_wr_t  rd_wr,
    input csr_reg_pkg::csr_sb_t csr_sb
);

    // Destination write is a single-cycle pulse
    a_rd_pulse: assert property (@(posedge aclk) disable iff (!aresetn)
        rd_wr.en |=> !rd_wr.en)
        else $error("rd_wr.en stayed high for more than one cycle");

    // Busy for two cycles after each acceptance, then ready again
    a_ready_gap: assert property (@(posedge aclk) disable iff (!aresetn)
        (valid && ready) |=> !ready ##1 !ready ##1 ready)
        else $error("ready did not follow the three-cycle acceptance pattern");

    // No stray write right out of reset
    a_rd_after_reset: assert property (@(posedge aclk)
        $rose(aresetn) |-> !rd_wr.en)
        else $error("rd_wr.en high in the first cycle after reset");

    // mepc is always word aligned
    a_mepc_align: assert property (@(posedge aclk) disable iff (!aresetn)
        csr_sb.mepc[1:0] == 2'b00)
        else $error("csr_sb.mepc has nonzero low bits");

endmodule

bind csr_unit csr_unit_sva u_sva (
    .aclk    (aclk),
    .aresetn (aresetn),
    .valid   (valid),
    .ready   (ready),
    .rd_wr   (rd_wr),
    .csr_sb  (csr_sb)
);

// File: csr_unit_tb.sv
/* Self-checking testbench for csr_unit with hart_id 5. Inputs change on the
   falling edge, and outputs are sampled there as well. */

`timescale 1ns/10ps

`include "csr_consts.svh"

module csr_unit_tb;

    localparam int              TMO         = 20;
    localparam logic [31:0]     HART_ID     = 32'd5;
    localparam logic [11:0]     UNIMPL_ADDR = 12'h7C0;

    logic                       aclk;
    logic                       aresetn;
    logic                       valid;
    logic                       ready;
    csr_isa_pkg::csr_instr_t    instbus;
    logic [`CSR_REG_W-1:0]      rs1_addr;
    logic [`CSR_XLEN-1:0]       rs1_val;
    csr_reg_pkg::rd_wr_t        rd_wr;
    csr_reg_pkg::trap_wr_t      trap_wr;
    logic [2:0]                 irq_drv;
    csr_reg_pkg::csr_sb_t       csr_sb;
    logic [2:0]                 pend;

    // Core register file and CSR mirror
    logic [31:0] xregs [0:31];
    logic [31:0] mdl [0:9];
    logic [31:0] lfsr_q;
    logic [31:0] last_rd;
    int          val_errs;
    int          proto_errs;
    string       test_name;

    // Register file answers in the same cycle
    assign rs1_val = xregs[rs1_addr];
    // Pin order ext, timer, sw
    assign pend    = {csr_sb.meip, csr_sb.mtip, csr_sb.msip};

    csr_unit #(
        .hart_id (HART_ID)
    ) UUT (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .valid     (valid),
        .ready     (ready),
        .instbus   (instbus),
        .rs1_addr  (rs1_addr),
        .rs1_val   (rs1_val),
        .rd_wr     (rd_wr),
        .trap_wr   (trap_wr),
        .ext_irq   (irq_drv[2]),
        .timer_irq (irq_drv[1]),
        .sw_irq    (irq_drv[0]),
        .csr_sb    (csr_sb)
    );

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Random source and reporting
    ////////////////////////////////////////////////////////////////////////////

    // Galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    task automatic report_value(input string what, input logic [31:0] exp,
                                input logic [31:0] act);
        $display("Fail %s %s expected %h actual %h", test_name, what, exp, act);
        val_errs++;
    endtask

    task automatic report_error(input string msg);
        $display("Error in %s: %s", test_name, msg);
        proto_errs++;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // CSR model
    ////////////////////////////////////////////////////////////////////////////

    // Index 10 and up is the unimplemented address
    function automatic logic [11:0] addr_at(input int n);
        case (n)
            0:       return `CSR_ADDR_MSTATUS;
            1:       return `CSR_ADDR_MISA;
            2:       return `CSR_ADDR_MIE;
            3:       return `CSR_ADDR_MTVEC;
            4:       return `CSR_ADDR_MSCRATCH;
            5:       return `CSR_ADDR_MEPC;
            6:       return `CSR_ADDR_MCAUSE;
            7:       return `CSR_ADDR_MTVAL;
            8:       return `CSR_ADDR_MIP;
            9:       return `CSR_ADDR_MHARTID;
            default: return UNIMPL_ADDR;
        endcase
    endfunction

    function automatic int csr_index(input logic [11:0] a);
        for (int n = 0; n < 10; n++) begin
            if (addr_at(n) == a) begin
                return n;
            end
        end
        return -1;
    endfunction

    function automatic logic [31:0] model_read(input logic [11:0] a);
        int n;
        n = csr_index(a);
        case (a)
            `CSR_ADDR_MISA:    return `CSR_MISA_VALUE;
            `CSR_ADDR_MHARTID: return HART_ID;
            default:           return (n < 0) ? 32'd0 : mdl[n];
        endcase
    endfunction

    function automatic void model_write(input logic [11:0] a, input logic [31:0] d);
        int n;
        n = csr_index(a);
        case (a)
            `CSR_ADDR_MSTATUS:                 mdl[n] = d & `CSR_MSTATUS_WMASK;
            `CSR_ADDR_MEPC:                    mdl[n] = d & `CSR_MEPC_WMASK;
            `CSR_ADDR_MISA, `CSR_ADDR_MHARTID: ;
            default: begin
                if (n >= 0) begin
                    mdl[n] = d;
                end
            end
        endcase
    endfunction

    // Applied after the instruction write, so traps win
    function automatic void trap_apply(input csr_reg_pkg::trap_wr_t t);
        if (t.mstatus_wr) model_write(`CSR_ADDR_MSTATUS, t.mstatus);
        if (t.mepc_wr)    model_write(`CSR_ADDR_MEPC, t.mepc);
        if (t.mcause_wr)  model_write(`CSR_ADDR_MCAUSE, t.mcause);
        if (t.mtval_wr)   model_write(`CSR_ADDR_MTVAL, t.mtval);
    endfunction

    function automatic csr_reg_pkg::trap_wr_t rand_trap();
        csr_reg_pkg::trap_wr_t t;
        t.mepc_wr    = take_bits(1);
        t.mepc       = take_bits(32);
        t.mstatus_wr = take_bits(1);
        t.mstatus    = take_bits(32);
        t.mcause_wr  = take_bits(1);
        t.mcause     = take_bits(32);
        t.mtval_wr   = take_bits(1);
        t.mtval      = take_bits(32);
        return t;
    endfunction

    task automatic check_bus();
        logic [31:0] m;
        m = model_read(`CSR_ADDR_MIP);
        if (csr_sb.mtvec !== model_read(`CSR_ADDR_MTVEC))
            report_value("bus mtvec", model_read(`CSR_ADDR_MTVEC), csr_sb.mtvec);
        if (csr_sb.mepc !== model_read(`CSR_ADDR_MEPC))
            report_value("bus mepc", model_read(`CSR_ADDR_MEPC), csr_sb.mepc);
        if (csr_sb.mstatus !== model_read(`CSR_ADDR_MSTATUS))
            report_value("bus mstatus", model_read(`CSR_ADDR_MSTATUS), csr_sb.mstatus);
        if (pend !== {m[`CSR_MEIP_BIT], m[`CSR_MTIP_BIT], m[`CSR_MSIP_BIT]})
            report_value("bus pending", {29'd0, m[`CSR_MEIP_BIT], m[`CSR_MTIP_BIT],
                         m[`CSR_MSIP_BIT]}, {29'd0, pend});
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    // Starts and ends on a falling edge; trap strobes meet the CSR write edge
    task automatic run_instr(input logic [2:0] f3, input logic [11:0] addr,
                             input logic [4:0] src, input logic [4:0] rd,
                             input csr_reg_pkg::trap_wr_t trap);
        logic [31:0] old;
        logic [31:0] opnd;
        logic [31:0] nv;
        logic        f3_ok;
        logic        wr;
        int          k;
        // Zicsr rules, bit 2 of funct3 picks the immediate
        old   = model_read(addr);
        opnd  = f3[2] ? {27'd0, src} : xregs[src];
        f3_ok = (f3[1:0] != 2'b00);
        wr    = f3_ok && ((f3[1:0] == 2'b01) || (src != 5'd0));
        case (f3[1:0])
            2'b01:   nv = opnd;
            2'b10:   nv = old | opnd;
            default: nv = old & ~opnd;
        endcase
        k = 0;
        while (ready !== 1'b1 && k < TMO) begin
            @(negedge aclk);
            k++;
        end
        if (ready !== 1'b1) report_error("ready never rose before the next instruction");
        instbus = {addr, src, f3, rd, 7'b1110011};
        valid   = 1'b1;
        @(posedge aclk);
        @(negedge aclk);
        valid = 1'b0;
        if (ready !== 1'b0) report_error("ready stayed high after acceptance");
        if (rs1_addr !== src)
            report_value("rs1 addr", {27'd0, src}, {27'd0, rs1_addr});
        k = 0;
        if (f3_ok) begin
            while (rd_wr.en !== 1'b1 && k < TMO) begin
                @(negedge aclk);
                k++;
            end
            if (rd_wr.en !== 1'b1) begin
                report_error("no destination write after acceptance");
            end else begin
                if (k != 1) report_error("destination write not one edge after acceptance");
                if (rd_wr.addr !== rd) report_value("rd addr", {27'd0, rd}, {27'd0, rd_wr.addr});
                if (rd_wr.data !== old) report_value("rd data", old, rd_wr.data);
                last_rd = rd_wr.data;
            end
        end else begin
            @(negedge aclk);
            if (rd_wr.en !== 1'b0) report_error("invalid funct3 produced a destination write");
        end
        if (ready !== 1'b0) report_error("ready rose before the third edge");
        trap_wr = trap;
        @(negedge aclk);
        trap_wr = '0;
        if (rd_wr.en !== 1'b0) report_error("destination write lasted more than one cycle");
        if (ready !== 1'b1) report_error("ready did not return at the third edge");
        if (f3_ok && rd != 5'd0) begin
            xregs[rd] = old;
        end
        if (wr) begin
            model_write(addr, nv);
        end
        trap_apply(trap);
        check_bus();
    endtask

    task automatic random_instr(input logic with_trap);
        int                    n;
        logic [2:0]            f3;
        logic [4:0]            src;
        csr_reg_pkg::trap_wr_t t;
        // Six valid codes map to 1 2 3 5 6 7
        n   = take_bits(3) % 6;
        f3  = 3'((n < 3) ? n + 1 : n + 2);
        n   = take_bits(4) % 11;
        src = 5'(take_bits(5));
        // Zero source now and then for the read-only forms
        if (take_bits(2) == 0) begin
            src = '0;
        end
        t = '0;
        if (with_trap) begin
            t = rand_trap();
        end
        run_instr(f3, addr_at(n), src, 5'(take_bits(5)), t);
    endtask

    // Trap strobe while no instruction is in flight
    task automatic idle_trap();
        csr_reg_pkg::trap_wr_t t;
        t       = rand_trap();
        trap_wr = t;
        @(negedge aclk);
        trap_wr = '0;
        trap_apply(t);
        check_bus();
    endtask

    task automatic write_read(input logic [11:0] addr, input logic [31:0] exp);
        run_instr(`CSR_F3_CSRRW, addr, 5'd1, 5'd0, '0);
        run_instr(`CSR_F3_CSRRS, addr, 5'd0, 5'd0, '0);
        if (last_rd !== exp) report_value("readback", exp, last_rd);
    endtask

    task automatic irq_check(input int pin, input int pos);
        int   k;
        logic seen;
        // Enabled pin latches its pending bit
        xregs[2] = 32'd1 << pos;
        run_instr(`CSR_F3_CSRRW, `CSR_ADDR_MIE, 5'd2, 5'd0, '0);
        irq_drv[pin] = 1'b1;
        k = 0;
        while (pend[pin] !== 1'b1 && k < TMO) begin
            @(negedge aclk);
            k++;
        end
        if (pend[pin] !== 1'b1) report_error("pending bit did not rise with its pin enabled");
        model_write(`CSR_ADDR_MIP, model_read(`CSR_ADDR_MIP) | (32'd1 << pos));
        irq_drv[pin] = 1'b0;
        // Let the synchronizer drain before software clears the bit
        repeat (4) @(negedge aclk);
        run_instr(`CSR_F3_CSRRC, `CSR_ADDR_MIP, 5'd2, 5'd0, '0);
        // Disabled pin must leave mip alone
        run_instr(`CSR_F3_CSRRW, `CSR_ADDR_MIE, 5'd0, 5'd0, '0);
        irq_drv[pin] = 1'b1;
        seen = 1'b0;
        for (k = 0; k < 10; k++) begin
            @(negedge aclk);
            if (pend[pin] !== 1'b0) seen = 1'b1;
        end
        if (seen) report_error("pending bit rose while its enable was clear");
        irq_drv[pin] = 1'b0;
        repeat (4) @(negedge aclk);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        lfsr_q     = 32'h43b;
        aresetn    = 1'b0;
        valid      = 1'b0;
        instbus    = '0;
        trap_wr    = '0;
        irq_drv    = '0;
        last_rd    = '0;
        val_errs   = 0;
        proto_errs = 0;
        test_name  = "reset";
        for (int i = 0; i < 32; i++) begin
            xregs[i] = (i == 0) ? 32'd0 : take_bits(32);
        end
        for (int n = 0; n < 10; n++) begin
            mdl[n] = '0;
        end
        repeat (5) @(negedge aclk);
        aresetn = 1'b1;
        @(negedge aclk);
        if (ready !== 1'b1) report_error("ready low after reset");
        if (rd_wr.en !== 1'b0) report_error("destination write high right after reset");

        // Handshake, invalid funct3 leaves mscratch untouched
        test_name = "handshake";
        run_instr(`CSR_F3_CSRRW, `CSR_ADDR_MSCRATCH, 5'd1, 5'd3, '0);
        run_instr(3'b000, `CSR_ADDR_MSCRATCH, 5'd4, 5'd3, '0);
        run_instr(3'b100, `CSR_ADDR_MSCRATCH, 5'd4, 5'd3, '0);
        run_instr(`CSR_F3_CSRRS, `CSR_ADDR_MSCRATCH, 5'd0, 5'd3, '0);

        test_name = "rmw";
        repeat (300) random_instr(1'b0);

        // Constant and masked registers
        test_name = "fixed";
        xregs[1]  = '1;
        write_read(`CSR_ADDR_MISA, `CSR_MISA_VALUE);
        write_read(`CSR_ADDR_MHARTID, HART_ID);
        write_read(UNIMPL_ADDR, 32'd0);
        write_read(`CSR_ADDR_MSTATUS, `CSR_MSTATUS_WMASK);
        write_read(`CSR_ADDR_MEPC, `CSR_MEPC_WMASK);

        test_name = "trap";
        repeat (100) begin
            if (take_bits(2) == 0) begin
                idle_trap();
            end else begin
                random_instr(1'b1);
            end
        end

        // Start from a clean mip
        test_name = "irq";
        run_instr(`CSR_F3_CSRRW, `CSR_ADDR_MIP, 5'd0, 5'd0, '0);
        irq_check(2, `CSR_MEIP_BIT);
        irq_check(1, `CSR_MTIP_BIT);
        irq_check(0, `CSR_MSIP_BIT);

        $display("value errors: %0d, other errors: %0d", val_errs, proto_errs);
        if (val_errs == 0 && proto_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
